// ==== src/exec_settings.svh ====
// Size settings for the execute slice, included by packages and RTL that need widths
`ifndef EXEC_SETTINGS_SVH
`define EXEC_SETTINGS_SVH

////////////////////////////////////////////////////////////
// Datapath sizing
////////////////////////////////////////////////////////////

// Register and operand width
`define EXEC_DATA_WIDTH 32

// 0 selects RV32I with 32 registers, 1 selects RV32E with 16
`define EXEC_RV32E 0

// Register count follows the base ISA choice
`define EXEC_NUM_REGS ((`EXEC_RV32E != 0) ? 16 : 32)

`endif

// ==== src/rv_isa_pkg.sv ====
// RISC-V instruction formats and encodings, referenced by scoped name from decoder and testbench
package rv_isa_pkg;

  ////////////////////////////////////////////////////////////
  // Instruction formats
  ////////////////////////////////////////////////////////////

  // OP format, register-register
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_type_t;

  // OP-IMM format, 12-bit immediate in the top bits
  typedef struct packed {
    logic [11:0] imm12;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_type_t;

  // One instruction word, read as either format
  // Opcode, rd, funct3 and rs1 sit in the same bits in both views
  typedef union packed {
    r_type_t rtype;
    i_type_t itype;
  } rv_instr_u;

  ////////////////////////////////////////////////////////////
  // Opcodes and function fields
  ////////////////////////////////////////////////////////////

  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

  localparam logic [2:0] F3_ADD  = 3'b000;
  localparam logic [2:0] F3_SLL  = 3'b001;
  localparam logic [2:0] F3_SLT  = 3'b010;
  localparam logic [2:0] F3_SLTU = 3'b011;
  localparam logic [2:0] F3_XOR  = 3'b100;
  // Shared by logical and arithmetic right shift
  localparam logic [2:0] F3_SR   = 3'b101;
  localparam logic [2:0] F3_OR   = 3'b110;
  localparam logic [2:0] F3_AND  = 3'b111;

  // Base encoding, and the alternate for SUB and SRA
  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_ALT  = 7'b0100000;

endpackage

// ==== src/exec_pkg.sv ====
// Datapath types of the execute slice, referenced by scoped name across the RTL
`include "exec_settings.svh"

package exec_pkg;

  ////////////////////////////////////////////////////////////
  // ALU operations
  ////////////////////////////////////////////////////////////

  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_SLL  = 4'd2,
    ALU_SLT  = 4'd3,
    ALU_SLTU = 4'd4,
    ALU_XOR  = 4'd5,
    ALU_SRL  = 4'd6,
    ALU_SRA  = 4'd7,
    ALU_OR   = 4'd8,
    ALU_AND  = 4'd9
  } alu_op_e;

  ////////////////////////////////////////////////////////////
  // Register file words
  ////////////////////////////////////////////////////////////

  // Full 5-bit index, also in RV32E mode
  typedef logic [4:0] reg_addr_t;

  // One register or operand
  typedef logic [`EXEC_DATA_WIDTH-1:0] word_t;

endpackage

// ==== src/instr_decoder.sv ====
// Input stage of the execute slice, decodes OP and OP-IMM words into a registered ALU command
`timescale 1ns/1ns
`include "exec_settings.svh"

module instr_decoder (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  instr_valid_i,
  input  rv_isa_pkg::rv_instr_u instr_i,
  output logic                  valid_o,
  output logic                  illegal_o,
  output exec_pkg::alu_op_e     alu_op_o,
  output exec_pkg::reg_addr_t   rs1_o,
  output exec_pkg::reg_addr_t   rs2_o,
  output exec_pkg::reg_addr_t   rd_o,
  output exec_pkg::word_t       imm_o,
  output logic                  use_imm_o
);

  logic                illegal_d;
  logic                use_imm_d;
  exec_pkg::alu_op_e   op_d;
  exec_pkg::reg_addr_t rs2_d;
  exec_pkg::word_t     imm_d;
  logic [6:0]          imm_hi;

  // Upper immediate bits, funct7 position for shift immediates
  assign imm_hi = instr_i.itype.imm12[11:5];

  ////////////////////////////////////////////////////////////
  // Combinational decode
  ////////////////////////////////////////////////////////////

  always_comb begin
    illegal_d = 1'b0;
    use_imm_d = 1'b0;
    op_d      = exec_pkg::ALU_ADD;
    rs2_d     = instr_i.rtype.rs2;
    // Sign-extended 12-bit immediate
    imm_d     = {{(`EXEC_DATA_WIDTH-12){instr_i.itype.imm12[11]}}, instr_i.itype.imm12};

    case (instr_i.rtype.opcode)
      rv_isa_pkg::OPC_OP: begin
        // Only ADD and SR accept the alternate funct7
        case (instr_i.rtype.funct3)
          rv_isa_pkg::F3_ADD:  op_d = exec_pkg::ALU_ADD;
          rv_isa_pkg::F3_SLL:  op_d = exec_pkg::ALU_SLL;
          rv_isa_pkg::F3_SLT:  op_d = exec_pkg::ALU_SLT;
          rv_isa_pkg::F3_SLTU: op_d = exec_pkg::ALU_SLTU;
          rv_isa_pkg::F3_XOR:  op_d = exec_pkg::ALU_XOR;
          rv_isa_pkg::F3_SR:   op_d = exec_pkg::ALU_SRL;
          rv_isa_pkg::F3_OR:   op_d = exec_pkg::ALU_OR;
          default:             op_d = exec_pkg::ALU_AND;
        endcase
        if (instr_i.rtype.funct7 == rv_isa_pkg::F7_ALT) begin
          if (instr_i.rtype.funct3 == rv_isa_pkg::F3_ADD) begin
            op_d = exec_pkg::ALU_SUB;
          end else if (instr_i.rtype.funct3 == rv_isa_pkg::F3_SR) begin
            op_d = exec_pkg::ALU_SRA;
          end else begin
            illegal_d = 1'b1;
          end
        end else if (instr_i.rtype.funct7 != rv_isa_pkg::F7_BASE) begin
          illegal_d = 1'b1;
        end
      end

      rv_isa_pkg::OPC_OP_IMM: begin
        use_imm_d = 1'b1;
        // No second register read for immediates
        rs2_d     = '0;
        case (instr_i.itype.funct3)
          rv_isa_pkg::F3_ADD:  op_d = exec_pkg::ALU_ADD;
          rv_isa_pkg::F3_SLT:  op_d = exec_pkg::ALU_SLT;
          rv_isa_pkg::F3_SLTU: op_d = exec_pkg::ALU_SLTU;
          rv_isa_pkg::F3_XOR:  op_d = exec_pkg::ALU_XOR;
          rv_isa_pkg::F3_OR:   op_d = exec_pkg::ALU_OR;
          rv_isa_pkg::F3_AND:  op_d = exec_pkg::ALU_AND;
          rv_isa_pkg::F3_SLL: begin
            op_d      = exec_pkg::ALU_SLL;
            imm_d     = exec_pkg::word_t'(instr_i.itype.imm12[4:0]);
            illegal_d = (imm_hi != rv_isa_pkg::F7_BASE);
          end
          default: begin
            // SRLI or SRAI, picked by the upper immediate bits
            op_d  = (imm_hi == rv_isa_pkg::F7_ALT) ? exec_pkg::ALU_SRA : exec_pkg::ALU_SRL;
            imm_d = exec_pkg::word_t'(instr_i.itype.imm12[4:0]);
            illegal_d = (imm_hi != rv_isa_pkg::F7_BASE) && (imm_hi != rv_isa_pkg::F7_ALT);
          end
        endcase
      end

      default: illegal_d = 1'b1;
    endcase

    // RV32E has only x0..x15
    if ((`EXEC_RV32E != 0) &&
        (instr_i.rtype.rs1[4] || instr_i.rtype.rd[4] || rs2_d[4])) begin
      illegal_d = 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////
  // Decode register
  ////////////////////////////////////////////////////////////

  // Strobe and illegal flag
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_o   <= 1'b0;
      illegal_o <= 1'b0;
    end else begin
      valid_o   <= instr_valid_i;
      illegal_o <= instr_valid_i & illegal_d;
    end
  end

  // Payload, qualified downstream by valid_o
  always_ff @(posedge clk) begin
    alu_op_o  <= op_d;
    rs1_o     <= instr_i.rtype.rs1;
    rs2_o     <= rs2_d;
    rd_o      <= instr_i.rtype.rd;
    imm_o     <= imm_d;
    use_imm_o <= use_imm_d;
  end

endmodule

// ==== src/register_file.sv ====
// Flip-flop register file with x0 tied to zero, two combinational reads and one write
`timescale 1ns/1ns
`include "exec_settings.svh"

module register_file (
  input  logic                clk,
  input  logic                rst_n,
  input  exec_pkg::reg_addr_t raddr_a_i,
  input  exec_pkg::reg_addr_t raddr_b_i,
  input  exec_pkg::reg_addr_t waddr_i,
  input  exec_pkg::word_t     wdata_i,
  input  logic                we_i,
  output exec_pkg::word_t     rdata_a_o,
  output exec_pkg::word_t     rdata_b_o
);

  localparam int NUM_REGS = `EXEC_NUM_REGS;

  exec_pkg::word_t                 regs [NUM_REGS-1:1];
  exec_pkg::word_t                 rf_words [NUM_REGS];
  logic            [NUM_REGS-1:1]  we_dec;

  ////////////////////////////////////////////////////////////
  // Write port
  ////////////////////////////////////////////////////////////

  // One-hot enable, no entry for x0
  always_comb begin
    for (int i = 1; i < NUM_REGS; i++) begin
      we_dec[i] = we_i && (waddr_i == exec_pkg::reg_addr_t'(i));
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 1; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else begin
      for (int i = 1; i < NUM_REGS; i++) begin
        if (we_dec[i]) begin
          regs[i] <= wdata_i;
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Read ports
  ////////////////////////////////////////////////////////////

  // Full view with constant zero at x0
  always_comb begin
    rf_words[0] = '0;
    for (int i = 1; i < NUM_REGS; i++) begin
      rf_words[i] = regs[i];
    end
  end

  // Indexes past the last register read zero
  assign rdata_a_o = (int'(raddr_a_i) < NUM_REGS) ? rf_words[raddr_a_i] : '0;
  assign rdata_b_o = (int'(raddr_b_i) < NUM_REGS) ? rf_words[raddr_b_i] : '0;

endmodule

// ==== src/alu.sv ====
// Combinational integer ALU of the execute slice, operand B picked from register or immediate
`timescale 1ns/1ns

module alu (
  input  exec_pkg::alu_op_e op_i,
  input  exec_pkg::word_t   rs1_data_i,
  input  exec_pkg::word_t   rs2_data_i,
  input  exec_pkg::word_t   imm_i,
  input  logic              use_imm_i,
  output exec_pkg::word_t   result_o
);

  exec_pkg::word_t op_a;
  exec_pkg::word_t op_b;
  logic [4:0]      shamt;
  logic            lt_signed;
  logic            lt_unsigned;

  // Operand select
  assign op_a  = rs1_data_i;
  assign op_b  = use_imm_i ? imm_i : rs2_data_i;

  // Shifts use the low 5 bits only
  assign shamt = op_b[4:0];

  // Compares for SLT and SLTU
  assign lt_signed   = $signed(op_a) < $signed(op_b);
  assign lt_unsigned = op_a < op_b;

  ////////////////////////////////////////////////////////////
  // Result mux
  ////////////////////////////////////////////////////////////

  always_comb begin
    case (op_i)
      exec_pkg::ALU_ADD:  result_o = op_a + op_b;
      // Wraps on overflow
      exec_pkg::ALU_SUB:  result_o = op_a - op_b;
      exec_pkg::ALU_SLL:  result_o = op_a << shamt;
      exec_pkg::ALU_SLT:  result_o = exec_pkg::word_t'(lt_signed);
      exec_pkg::ALU_SLTU: result_o = exec_pkg::word_t'(lt_unsigned);
      exec_pkg::ALU_XOR:  result_o = op_a ^ op_b;
      exec_pkg::ALU_SRL:  result_o = op_a >> shamt;
      // Sign bit fills from the left
      exec_pkg::ALU_SRA:  result_o = exec_pkg::word_t'($signed(op_a) >>> shamt);
      exec_pkg::ALU_OR:   result_o = op_a | op_b;
      exec_pkg::ALU_AND:  result_o = op_a & op_b;
      default:            result_o = '0;
    endcase
  end

endmodule

// ==== src/writeback_stage.sv ====
// Output stage of the execute slice, drives the register file write and registers the report
`timescale 1ns/1ns

module writeback_stage (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                valid_i,
  input  logic                illegal_i,
  input  exec_pkg::reg_addr_t rd_i,
  input  exec_pkg::word_t     result_i,
  output logic                rf_we_o,
  output exec_pkg::reg_addr_t rf_waddr_o,
  output exec_pkg::word_t     rf_wdata_o,
  output logic                result_valid_o,
  output exec_pkg::reg_addr_t result_rd_o,
  output exec_pkg::word_t     result_data_o,
  output logic                illegal_o,
  output logic [31:0]         retired_count_o
);

  // Write only for a valid, legal instruction
  // x0 is dropped inside the register file
  assign rf_we_o    = valid_i & ~illegal_i;
  assign rf_waddr_o = rd_i;
  assign rf_wdata_o = result_i;

  ////////////////////////////////////////////////////////////
  // Result report and retire count
  ////////////////////////////////////////////////////////////

  // One-cycle pulses, counter wraps at 2**32
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      result_valid_o  <= 1'b0;
      illegal_o       <= 1'b0;
      retired_count_o <= '0;
    end else begin
      result_valid_o <= rf_we_o;
      illegal_o      <= valid_i & illegal_i;
      if (rf_we_o) begin
        retired_count_o <= retired_count_o + 32'd1;
      end
    end
  end

  // Reported rd and data, qualified by result_valid_o
  always_ff @(posedge clk) begin
    result_rd_o   <= rd_i;
    result_data_o <= result_i;
  end

endmodule

// ==== src/exec_slice_top.sv ====
// Top level of the integer execute slice, wires decoder, register file, ALU and writeback
`timescale 1ns/1ns

module exec_slice_top (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  instr_valid_i,
  input  rv_isa_pkg::rv_instr_u instr_i,
  output logic                  result_valid_o,
  output exec_pkg::reg_addr_t   result_rd_o,
  output exec_pkg::word_t       result_data_o,
  output logic                  illegal_o,
  output logic [31:0]           retired_count_o
);

  // Decode register outputs
  logic                dec_valid;
  logic                dec_illegal;
  exec_pkg::alu_op_e   dec_op;
  exec_pkg::reg_addr_t dec_rs1;
  exec_pkg::reg_addr_t dec_rs2;
  exec_pkg::reg_addr_t dec_rd;
  exec_pkg::word_t     dec_imm;
  logic                dec_use_imm;

  // Operands, result and write port
  exec_pkg::word_t     rs1_data;
  exec_pkg::word_t     rs2_data;
  exec_pkg::word_t     alu_result;
  logic                rf_we;
  exec_pkg::reg_addr_t rf_waddr;
  exec_pkg::word_t     rf_wdata;

  ////////////////////////////////////////////////////////////
  // Input side
  ////////////////////////////////////////////////////////////

  instr_decoder u_decoder (
    .clk           (clk),
    .rst_n         (rst_n),
    .instr_valid_i (instr_valid_i),
    .instr_i       (instr_i),
    .valid_o       (dec_valid),
    .illegal_o     (dec_illegal),
    .alu_op_o      (dec_op),
    .rs1_o         (dec_rs1),
    .rs2_o         (dec_rs2),
    .rd_o          (dec_rd),
    .imm_o         (dec_imm),
    .use_imm_o     (dec_use_imm)
  );

  ////////////////////////////////////////////////////////////
  // Operand read and execute
  ////////////////////////////////////////////////////////////

  register_file u_regfile (
    .clk       (clk),
    .rst_n     (rst_n),
    .raddr_a_i (dec_rs1),
    .raddr_b_i (dec_rs2),
    .waddr_i   (rf_waddr),
    .wdata_i   (rf_wdata),
    .we_i      (rf_we),
    .rdata_a_o (rs1_data),
    .rdata_b_o (rs2_data)
  );

  alu u_alu (
    .op_i       (dec_op),
    .rs1_data_i (rs1_data),
    .rs2_data_i (rs2_data),
    .imm_i      (dec_imm),
    .use_imm_i  (dec_use_imm),
    .result_o   (alu_result)
  );

  ////////////////////////////////////////////////////////////
  // Output side
  ////////////////////////////////////////////////////////////

  writeback_stage u_writeback (
    .clk             (clk),
    .rst_n           (rst_n),
    .valid_i         (dec_valid),
    .illegal_i       (dec_illegal),
    .rd_i            (dec_rd),
    .result_i        (alu_result),
    .rf_we_o         (rf_we),
    .rf_waddr_o      (rf_waddr),
    .rf_wdata_o      (rf_wdata),
    .result_valid_o  (result_valid_o),
    .result_rd_o     (result_rd_o),
    .result_data_o   (result_data_o),
    .illegal_o       (illegal_o),
    .retired_count_o (retired_count_o)
  );

endmodule

// ==== dv/tb_clk_gen.sv ====
// Testbench clock and reset source for the execute slice, instantiated by the testbench top
`timescale 1ns/1ns

module tb_clk_gen #(
  parameter int PERIOD       = 8,
  parameter int RESET_CYCLES = 5
) (
  output logic clk_o,
  output logic rst_n_o
);

  // Free-running clock, first rising edge at half a period
  initial begin
    clk_o = 1'b0;
    forever #(PERIOD / 2) clk_o = ~clk_o;
  end

  // Reset spans RESET_CYCLES rising edges
  // Release sits a quarter period away from any clock edge
  initial begin
    rst_n_o = 1'b0;
    #(PERIOD * RESET_CYCLES + PERIOD / 4);
    rst_n_o = 1'b1;
  end

endmodule

// ==== dv/exec_slice_tb.sv ====
// Table-driven and random testbench for the execute slice, run as the simulation top
`timescale 1ns/1ns

module exec_slice_tb;

  localparam int PERIOD       = 8;
  localparam int RESET_CYCLES = 5;
  localparam int NUM_RANDOM   = 200;
  localparam bit EXP_RESULT   = 1'b0;
  localparam bit EXP_ILLEGAL  = 1'b1;

  logic                  clk;
  logic                  rst_n;
  logic                  instr_valid_i;
  rv_isa_pkg::rv_instr_u instr_i;
  logic                  result_valid_o;
  exec_pkg::reg_addr_t   result_rd_o;
  exec_pkg::word_t       result_data_o;
  logic                  illegal_o;
  logic [31:0]           retired_count_o;

  // Stimulus table, one entry per index
  string                 tbl_name [$];
  rv_isa_pkg::rv_instr_u tbl_instr [$];
  bit                    tbl_illegal [$];
  exec_pkg::reg_addr_t   tbl_rd [$];
  exec_pkg::word_t       tbl_data [$];

  // Expected results in issue order
  string                 exp_name_q [$];
  bit                    exp_illegal_q [$];
  exec_pkg::reg_addr_t   exp_rd_q [$];
  exec_pkg::word_t       exp_data_q [$];

  // Reference register state
  exec_pkg::word_t       model_regs [32];
  int unsigned           legal_count = 0;
  integer                seed = 62540;
  logic [1:0]            in_flight = 2'b00;
  int                    cycle_cnt = 0;
  int                    cycle_limit = 0;

  tb_clk_gen #(
    .PERIOD       (PERIOD),
    .RESET_CYCLES (RESET_CYCLES)
  ) u_clk_gen (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  exec_slice_top dut (
    .clk             (clk),
    .rst_n           (rst_n),
    .instr_valid_i   (instr_valid_i),
    .instr_i         (instr_i),
    .result_valid_o  (result_valid_o),
    .result_rd_o     (result_rd_o),
    .result_data_o   (result_data_o),
    .illegal_o       (illegal_o),
    .retired_count_o (retired_count_o)
  );

  ////////////////////////////////////////////////////////////
  // Error handling and compare tasks
  ////////////////////////////////////////////////////////////

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("TB FAILED");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic check_word(input string name, input exec_pkg::word_t exp,
                            input exec_pkg::word_t act);
    if (act !== exp) begin
      abort_run($sformatf("Fail %s: expected %h, actual %h", name, exp, act));
    end
  endtask

  task automatic check_addr(input string name, input exec_pkg::reg_addr_t exp,
                            input exec_pkg::reg_addr_t act);
    if (act !== exp) begin
      abort_run($sformatf("Fail %s: expected %0d, actual %0d", name, exp, act));
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      abort_run($sformatf("Fail %s: expected %b, actual %b", name, exp, act));
    end
  endtask

  task automatic check_count(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
    if (act !== exp) begin
      abort_run($sformatf("Fail %s: expected %0d, actual %0d", name, exp, act));
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Instruction builders and reference model
  ////////////////////////////////////////////////////////////

  function automatic rv_isa_pkg::rv_instr_u op_reg(input logic [2:0] f3, input logic [6:0] f7,
      input exec_pkg::reg_addr_t rd, input exec_pkg::reg_addr_t rs1,
      input exec_pkg::reg_addr_t rs2);
    rv_isa_pkg::rv_instr_u w;
    w.rtype.funct7 = f7;
    w.rtype.rs2    = rs2;
    w.rtype.rs1    = rs1;
    w.rtype.funct3 = f3;
    w.rtype.rd     = rd;
    w.rtype.opcode = rv_isa_pkg::OPC_OP;
    return w;
  endfunction

  function automatic rv_isa_pkg::rv_instr_u op_imm(input logic [2:0] f3,
      input exec_pkg::reg_addr_t rd, input exec_pkg::reg_addr_t rs1, input logic [11:0] imm);
    rv_isa_pkg::rv_instr_u w;
    w.itype.imm12  = imm;
    w.itype.rs1    = rs1;
    w.itype.funct3 = f3;
    w.itype.rd     = rd;
    w.itype.opcode = rv_isa_pkg::OPC_OP_IMM;
    return w;
  endfunction

  function automatic exec_pkg::word_t sext12(input logic [11:0] imm);
    return {{20{imm[11]}}, imm};
  endfunction

  // ISA result of a legal OP or OP-IMM word on the model registers
  function automatic exec_pkg::word_t model_result(input rv_isa_pkg::rv_instr_u w);
    exec_pkg::word_t a;
    exec_pkg::word_t b;
    logic [4:0]      sh;
    logic            alt;
    logic            lt_s;
    logic            is_op;
    exec_pkg::word_t res;
    is_op = (w.rtype.opcode == rv_isa_pkg::OPC_OP);
    a     = model_regs[w.rtype.rs1];
    // Bit 30 marks SUB and SRA in both formats
    b     = is_op ? model_regs[w.rtype.rs2] : sext12(w.itype.imm12);
    alt   = w.rtype.funct7[5];
    sh    = b[4:0];
    // Sign differs, so the negative one is smaller
    lt_s  = (a[31] != b[31]) ? a[31] : (a < b);
    case (w.rtype.funct3)
      rv_isa_pkg::F3_ADD:  res = (is_op && alt) ? a - b : a + b;
      rv_isa_pkg::F3_SLL:  res = a << sh;
      rv_isa_pkg::F3_SLT:  res = lt_s ? exec_pkg::word_t'(1) : '0;
      rv_isa_pkg::F3_SLTU: res = (a < b) ? exec_pkg::word_t'(1) : '0;
      rv_isa_pkg::F3_XOR:  res = a ^ b;
      // Arithmetic shift fills the vacated top bits with the sign
      rv_isa_pkg::F3_SR:   res = (a >> sh) | ((alt && a[31]) ? ~(32'hFFFF_FFFF >> sh) : '0);
      rv_isa_pkg::F3_OR:   res = a | b;
      default:             res = a & b;
    endcase
    return res;
  endfunction

  // Legal OP or OP-IMM word from one random draw
  task automatic random_instr(output rv_isa_pkg::rv_instr_u w);
    logic [31:0] r;
    logic [2:0]  f3;
    logic [11:0] imm;
    r   = $random(seed);
    f3  = r[2:0];
    imm = r[31:20];
    if (r[3]) begin
      w = op_reg(f3, ((f3 == rv_isa_pkg::F3_ADD || f3 == rv_isa_pkg::F3_SR) && r[4]) ?
                 rv_isa_pkg::F7_ALT : rv_isa_pkg::F7_BASE, r[19:15], r[14:10], r[9:5]);
    end else begin
      if (f3 == rv_isa_pkg::F3_SLL) begin
        imm = {rv_isa_pkg::F7_BASE, imm[4:0]};
      end else if (f3 == rv_isa_pkg::F3_SR) begin
        imm = {r[4] ? rv_isa_pkg::F7_ALT : rv_isa_pkg::F7_BASE, imm[4:0]};
      end
      w = op_imm(f3, r[19:15], r[14:10], imm);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Table and driver
  ////////////////////////////////////////////////////////////

  task automatic add_entry(input string name, input rv_isa_pkg::rv_instr_u w, input bit ill,
                           input exec_pkg::reg_addr_t rd, input exec_pkg::word_t data);
    tbl_name.push_back(name);
    tbl_instr.push_back(w);
    tbl_illegal.push_back(ill);
    tbl_rd.push_back(rd);
    tbl_data.push_back(data);
  endtask

  // Drive one word and queue what it should report
  task automatic issue_instr(input string name, input rv_isa_pkg::rv_instr_u w, input bit ill,
                             input exec_pkg::reg_addr_t rd, input exec_pkg::word_t data);
    @(posedge clk);
    instr_valid_i <= 1'b1;
    instr_i       <= w;
    exp_name_q.push_back(name);
    exp_illegal_q.push_back(ill);
    exp_rd_q.push_back(rd);
    exp_data_q.push_back(data);
    if (!ill) begin
      legal_count++;
      if (rd != '0) begin
        model_regs[rd] = data;
      end
    end
  endtask

  // Output check at the falling edge, two edges after the word was driven
  always @(negedge clk) begin : check_outputs
    string               name;
    bit                  ill;
    exec_pkg::reg_addr_t rd;
    exec_pkg::word_t     data;
    if (rst_n) begin
      if (in_flight[1]) begin
        name = exp_name_q.pop_front();
        ill  = exp_illegal_q.pop_front();
        rd   = exp_rd_q.pop_front();
        data = exp_data_q.pop_front();
        check_flag({name, " result_valid"}, ~ill, result_valid_o);
        check_flag({name, " illegal"}, ill, illegal_o);
        if (!ill) begin
          check_addr({name, " rd"}, rd, result_rd_o);
          check_word({name, " data"}, data, result_data_o);
        end
      end else begin
        check_flag("idle result_valid", 1'b0, result_valid_o);
        check_flag("idle illegal", 1'b0, illegal_o);
      end
      in_flight = {in_flight[0], instr_valid_i};
    end
  end

  // Run limit
  always @(posedge clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt > cycle_limit) begin
      abort_run($sformatf("Timeout, test still running after %0d cycles", cycle_cnt));
    end
  end

  ////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////

  initial begin
    rv_isa_pkg::rv_instr_u w;
    instr_valid_i = 1'b0;
    instr_i       = '0;
    for (int i = 0; i < 32; i++) begin
      model_regs[i] = '0;
    end

    // ADDI chain, x4 and x5 depend on the entry just before
    add_entry("addi_x1", op_imm(rv_isa_pkg::F3_ADD, 5'd1, 5'd0, 12'd5), EXP_RESULT, 5'd1, 32'd5);
    add_entry("addi_x2", op_imm(rv_isa_pkg::F3_ADD, 5'd2, 5'd0, 12'hFFD),
              EXP_RESULT, 5'd2, 32'hFFFF_FFFD);
    add_entry("addi_x3", op_imm(rv_isa_pkg::F3_ADD, 5'd3, 5'd0, 12'h7FF),
              EXP_RESULT, 5'd3, 32'h0000_07FF);
    add_entry("addi_x4_dep", op_imm(rv_isa_pkg::F3_ADD, 5'd4, 5'd1, 12'd10),
              EXP_RESULT, 5'd4, 32'd15);
    add_entry("addi_x5_dep", op_imm(rv_isa_pkg::F3_ADD, 5'd5, 5'd4, 12'd1),
              EXP_RESULT, 5'd5, 32'd16);
    add_entry("slli_x6", op_imm(rv_isa_pkg::F3_SLL, 5'd6, 5'd5, 12'h01B),
              EXP_RESULT, 5'd6, 32'h8000_0000);
    // Register-register operations
    add_entry("add", op_reg(rv_isa_pkg::F3_ADD, rv_isa_pkg::F7_BASE, 5'd7, 5'd1, 5'd2),
              EXP_RESULT, 5'd7, 32'd2);
    add_entry("sub_wrap", op_reg(rv_isa_pkg::F3_ADD, rv_isa_pkg::F7_ALT, 5'd8, 5'd6, 5'd1),
              EXP_RESULT, 5'd8, 32'h7FFF_FFFB);
    add_entry("sll", op_reg(rv_isa_pkg::F3_SLL, rv_isa_pkg::F7_BASE, 5'd9, 5'd1, 5'd1),
              EXP_RESULT, 5'd9, 32'h0000_00A0);
    add_entry("slt_neg", op_reg(rv_isa_pkg::F3_SLT, rv_isa_pkg::F7_BASE, 5'd10, 5'd2, 5'd1),
              EXP_RESULT, 5'd10, 32'd1);
    add_entry("sltu_neg", op_reg(rv_isa_pkg::F3_SLTU, rv_isa_pkg::F7_BASE, 5'd11, 5'd2, 5'd1),
              EXP_RESULT, 5'd11, 32'd0);
    add_entry("xor", op_reg(rv_isa_pkg::F3_XOR, rv_isa_pkg::F7_BASE, 5'd12, 5'd2, 5'd3),
              EXP_RESULT, 5'd12, 32'hFFFF_F802);
    add_entry("srl_neg", op_reg(rv_isa_pkg::F3_SR, rv_isa_pkg::F7_BASE, 5'd13, 5'd2, 5'd1),
              EXP_RESULT, 5'd13, 32'h07FF_FFFF);
    add_entry("sra_neg", op_reg(rv_isa_pkg::F3_SR, rv_isa_pkg::F7_ALT, 5'd14, 5'd2, 5'd1),
              EXP_RESULT, 5'd14, 32'hFFFF_FFFF);
    add_entry("or", op_reg(rv_isa_pkg::F3_OR, rv_isa_pkg::F7_BASE, 5'd15, 5'd1, 5'd3),
              EXP_RESULT, 5'd15, 32'h0000_07FF);
    add_entry("and", op_reg(rv_isa_pkg::F3_AND, rv_isa_pkg::F7_BASE, 5'd16, 5'd2, 5'd3),
              EXP_RESULT, 5'd16, 32'h0000_07FD);
    add_entry("sra_min", op_reg(rv_isa_pkg::F3_SR, rv_isa_pkg::F7_ALT, 5'd17, 5'd6, 5'd1),
              EXP_RESULT, 5'd17, 32'hFC00_0000);
    // Immediate operations
    add_entry("slti", op_imm(rv_isa_pkg::F3_SLT, 5'd18, 5'd2, 12'hFFF),
              EXP_RESULT, 5'd18, 32'd1);
    add_entry("sltiu", op_imm(rv_isa_pkg::F3_SLTU, 5'd19, 5'd1, 12'hFFF),
              EXP_RESULT, 5'd19, 32'd1);
    add_entry("xori", op_imm(rv_isa_pkg::F3_XOR, 5'd20, 5'd1, 12'hFFF),
              EXP_RESULT, 5'd20, 32'hFFFF_FFFA);
    add_entry("ori", op_imm(rv_isa_pkg::F3_OR, 5'd21, 5'd1, 12'h0F0),
              EXP_RESULT, 5'd21, 32'h0000_00F5);
    add_entry("andi", op_imm(rv_isa_pkg::F3_AND, 5'd22, 5'd2, 12'h0F0),
              EXP_RESULT, 5'd22, 32'h0000_00F0);
    add_entry("srli", op_imm(rv_isa_pkg::F3_SR, 5'd23, 5'd6, 12'h004),
              EXP_RESULT, 5'd23, 32'h0800_0000);
    add_entry("srai", op_imm(rv_isa_pkg::F3_SR, 5'd24, 5'd6, 12'h404),
              EXP_RESULT, 5'd24, 32'hF800_0000);
    // x0 reports the sum, then still reads zero
    add_entry("addi_x0", op_imm(rv_isa_pkg::F3_ADD, 5'd0, 5'd1, 12'd7),
              EXP_RESULT, 5'd0, 32'd12);
    add_entry("add_x0_read", op_reg(rv_isa_pkg::F3_ADD, rv_isa_pkg::F7_BASE, 5'd25, 5'd0, 5'd1),
              EXP_RESULT, 5'd25, 32'd5);
    // LOAD opcode in the I-type view
    w = op_imm(rv_isa_pkg::F3_SLT, 5'd1, 5'd2, 12'h000);
    w.itype.opcode = 7'b0000011;
    add_entry("bad_opcode", w, EXP_ILLEGAL, 5'd0, 32'd0);
    add_entry("bad_funct7", op_reg(rv_isa_pkg::F3_ADD, 7'b0000001, 5'd2, 5'd1, 5'd1),
              EXP_ILLEGAL, 5'd0, 32'd0);
    add_entry("bad_slli", op_imm(rv_isa_pkg::F3_SLL, 5'd3, 5'd1, 12'h405),
              EXP_ILLEGAL, 5'd0, 32'd0);
    // x1, x2 and x3 untouched by the illegal words
    add_entry("add_after_illegal",
              op_reg(rv_isa_pkg::F3_ADD, rv_isa_pkg::F7_BASE, 5'd26, 5'd1, 5'd2),
              EXP_RESULT, 5'd26, 32'd2);
    add_entry("addi_after_illegal", op_imm(rv_isa_pkg::F3_ADD, 5'd27, 5'd3, 12'd0),
              EXP_RESULT, 5'd27, 32'h0000_07FF);

    cycle_limit = tbl_name.size() + NUM_RANDOM + RESET_CYCLES + 20;

    @(posedge rst_n);
    for (int i = 0; i < tbl_name.size(); i++) begin
      issue_instr(tbl_name[i], tbl_instr[i], tbl_illegal[i], tbl_rd[i], tbl_data[i]);
    end

    // Random legal stream, back to back after the table
    for (int i = 0; i < NUM_RANDOM; i++) begin
      random_instr(w);
      issue_instr($sformatf("rand_%0d", i), w, EXP_RESULT, w.rtype.rd, model_result(w));
    end
    @(posedge clk);
    instr_valid_i <= 1'b0;

    while (exp_name_q.size() != 0) begin
      @(posedge clk);
    end
    @(negedge clk);
    check_count("retired_count", legal_count, retired_count_o);
    $display("TB PASSED");
    $finish;
  end

endmodule

// ==== exec_slice.f ====
+incdir+src
src/rv_isa_pkg.sv
src/exec_pkg.sv
src/instr_decoder.sv
src/register_file.sv
src/alu.sv
src/writeback_stage.sv
src/exec_slice_top.sv
dv/tb_clk_gen.sv
dv/exec_slice_tb.sv

// ==== Makefile ====
# Verilator build and run of the execute slice testbench

VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = exec_slice_tb
FILELIST  = exec_slice.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# The log decides pass or fail
run: compile
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "TB PASSED" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
